/* filelist.f */
+incdir+hw
hw/wb_pkg.sv
hw/isa_pkg.sv
hw/reg_id_ex.sv
hw/exec_unit.sv
hw/load_store_unit.sv
hw/wb_arbiter.sv
hw/data_ram.sv
hw/backend_top.sv
testbench/backend_sva.sv
testbench/tb_backend.sv

/* Bender.yml */
package:
  name: mips_backend

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_pkg.sv
      - hw/isa_pkg.sv
      - hw/reg_id_ex.sv
      - hw/exec_unit.sv
      - hw/load_store_unit.sv
      - hw/wb_arbiter.sv
      - hw/data_ram.sv
      - hw/backend_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/backend_sva.sv
      - testbench/tb_backend.sv

/* testbench/tb_backend.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module tb_backend;
    import isa_pkg::*;
    import wb_pkg::*;

    logic        i_clk;
    logic        i_arst_n;
    id_ex_t      issue;
    logic        ready;
    wb_result_t  wb;
    redirect_t   redirect;
    wb_req_t     ext_req;
    wb_rsp_t     ext_rsp;

    string       names[$];
    id_ex_t      ids[$];
    wb_result_t  exp_wb[$];
    redirect_t   exp_rd[$];
    bit          contend[$];
    int          pre_idx[$];
    int          st_idx[$];
    word_t       model [`CORE_MEM_WORDS];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          limit;

    backend_top i_dut (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_issue    (issue),
        .o_ready    (ready),
        .o_wb       (wb),
        .o_redirect (redirect),
        .i_ext_req  (ext_req),
        .o_ext_rsp  (ext_rsp)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
        int    s;
        word_t r;
        s = int'(b[4:0]);
        case (op)
            alu_add:  r = a + b;
            alu_sub:  r = a + ~b + 1;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_slt:  r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            alu_sltu: r = word_t'(a < b);
            alu_sll:  r = a << s;
            alu_srl:  r = a >> s;
            alu_sra:  r = (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
            alu_lui:  r = b << 16;
            default:  r = b;
        endcase
        return r;
    endfunction

    // misaligned accesses fall back to the natural boundary
    function automatic word_t load_ref(word_t addr, mem_size_e sz, logic uns);
        word_t w;
        word_t v;
        w = model[addr[9:2]];
        case (sz)
            mem_byte: begin
                v = (w >> (8 * int'(addr[1:0]))) & 32'hff;
                if (!uns && v[7]) v = v | 32'hffffff00;
            end
            mem_half: begin
                v = (w >> (16 * int'(addr[1]))) & 32'hffff;
                if (!uns && v[15]) v = v | 32'hffff0000;
            end
            default: v = w;
        endcase
        return v;
    endfunction

    task automatic store_apply(word_t addr, mem_size_e sz, word_t d);
        case (sz)
            mem_byte: model[addr[9:2]][8*int'(addr[1:0]) +: 8] = d[7:0];
            mem_half: model[addr[9:2]][16*int'(addr[1]) +: 16] = d[15:0];
            default:  model[addr[9:2]] = d;
        endcase
        st_idx.push_back(int'(addr[9:2]));
    endtask

    task automatic add_entry(string name, id_ex_t id, wb_result_t w, redirect_t r, bit c);
        names.push_back(name);
        ids.push_back(id);
        exp_wb.push_back(w);
        exp_rd.push_back(r);
        contend.push_back(c);
    endtask

    // base sits past the address so the AGU adds a negative offset
    task automatic add_mem(string name, bit st, word_t addr, mem_size_e sz, logic uns, bit c);
        id_ex_t     id;
        wb_result_t w;
        id = '0;
        w = '0;
        id.valid = 1'b1;
        id.agu_op = st ? agu_store : agu_load;
        id.base = addr + 12;
        id.offset = 26'(-12);
        id.mem_size = sz;
        id.mem_unsigned = uns;
        id.rd = 5'(next_rand());
        id.src_b = next_rand();
        id.reg_wr_en = !st;
        if (st) begin
            store_apply(addr, sz, id.src_b);
        end else begin
            w.en = 1'b1;
            w.rd = id.rd;
            w.data = load_ref(addr, sz, uns);
        end
        add_entry(name, id, w, '0, c);
    endtask

    task automatic add_branch(string name, agu_op_e op, bit eq);
        id_ex_t     id;
        wb_result_t w;
        redirect_t  r;
        int         ofs;
        id = '0;
        w = '0;
        id.valid = 1'b1;
        id.agu_op = op;
        id.pc = next_rand() & 32'hfffffffc;
        id.src_a = next_rand();
        id.src_b = eq ? id.src_a : id.src_a ^ 32'h10;
        ofs = int'(next_rand() & 32'h3ff) - 512;
        if (op == agu_jump || op == agu_jal) begin
            id.offset = 26'(next_rand());
            r.taken = 1'b1;
            r.target = {4'b0000, id.offset, 2'b00};
            r.target[31:28] = 4'((id.pc + 4) >> 28);
        end else begin
            id.offset = 26'(ofs);
            r.taken = (op == agu_beq) ? eq : !eq;
            r.target = id.pc + 4 + (word_t'(ofs) << 2);
        end
        if (op == agu_jal) begin
            id.rd = 5'd31;
            id.reg_wr_en = 1'b1;
            w = '{en: 1'b1, rd: 5'd31, data: id.pc + 8};
        end
        if (!r.taken) r.target = '0;
        add_entry(name, id, w, r, 1'b0);
    endtask

    task automatic build_table();
        id_ex_t     id;
        word_t      addr;
        mem_size_e  sz;
        for (int k = 0; k < 12; k++) begin
            id = '0;
            id.valid = 1'b1;
            id.alu_op = alu_op_e'(k);
            id.src_a = next_rand();
            id.src_b = next_rand();
            id.rd = 5'(k + 1);
            id.reg_wr_en = 1'b1;
            add_entry($sformatf("alu op %0d", k), id,
                      '{en: 1'b1, rd: id.rd, data: alu_ref(id.alu_op, id.src_a, id.src_b)},
                      '0, 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            addr = next_rand() & 32'hff;            // words 0 to 63
            sz = mem_size_e'(k % 3);
            add_mem($sformatf("store %0d", k), 1'b1, addr, sz, 1'b0, 1'b0);
            add_mem($sformatf("load signed %0d", k), 1'b0, addr, sz, 1'b0, 1'b0);
            add_mem($sformatf("load unsigned %0d", k), 1'b0, addr, sz, 1'b1, 1'b0);
        end
        add_branch("beq taken", agu_beq, 1'b1);
        add_branch("beq not taken", agu_beq, 1'b0);
        add_branch("bne taken", agu_bne, 1'b0);
        add_branch("bne not taken", agu_bne, 1'b1);
        add_branch("jump", agu_jump, 1'b0);
        add_branch("jump and link", agu_jal, 1'b0);
        // the external preload region covers words 64 to 71
        for (int j = 0; j < 8; j++) begin
            pre_idx.push_back(64 + j);
            model[64 + j] = next_rand();
        end
        for (int j = 0; j < 14; j++) begin
            addr = word_t'((64 + (j % 8)) * 4) + (next_rand() & 3);
            add_mem(j < 8 ? $sformatf("preload read %0d", j) : $sformatf("contention %0d", j),
                    1'b0, addr, mem_size_e'(j % 3), 1'(j >> 1), j >= 8);
        end
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(string what, logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic ext_xfer(logic we, int idx, word_t dat, output word_t rdat);
        ext_req.cyc = 1'b1;
        ext_req.stb = 1'b1;
        ext_req.we = we;
        ext_req.adr = 30'(idx);
        ext_req.dat = dat;
        ext_req.sel = 4'hf;
        step();
        while (!ext_rsp.ack) step();
        rdat = ext_rsp.dat;
        step();                             // cyc drops the cycle after ack
        ext_req = '0;
    endtask

    task automatic ext_check(string name, int idx, int delay);
        word_t rdat;
        repeat (delay) step();
        ext_xfer(1'b0, idx, '0, rdat);
        check_word(name, model[idx], rdat);
    endtask

    task automatic run_entry(int n);
        id_ex_t id;
        bit     mem;
        bit     br;
        id = ids[n];
        mem = (id.agu_op == agu_load) || (id.agu_op == agu_store);
        br = (id.agu_op >= agu_beq);
        while (!ready) step();
        issue = id;
        step();                             // accepted on this edge
        check_word({names[n], " taken"}, word_t'(exp_rd[n].taken), word_t'(redirect.taken));
        if (exp_rd[n].taken) begin
            check_word({names[n], " target"}, exp_rd[n].target, redirect.target);
        end
        issue = '0;
        if (br) begin
            issue.valid = 1'b1;             // shadow add that writes 1 + 2 to rd 30
            issue.src_a = 32'd1;
            issue.src_b = 32'd2;
            issue.rd = 5'd30;
            issue.reg_wr_en = 1'b1;
        end
        step();
        issue = '0;
        if (mem) begin
            check_true({names[n], ": hold did not rise for the memory access"}, !ready);
            while (!ready) begin
                check_true({names[n], ": writeback came while still held"}, !wb.en);
                step();
            end
        end
        check_word({names[n], " wb en"}, word_t'(exp_wb[n].en), word_t'(wb.en));
        if (exp_wb[n].en) begin
            check_word({names[n], " wb rd"}, word_t'(exp_wb[n].rd), word_t'(wb.rd));
            check_word({names[n], " wb data"}, exp_wb[n].data, wb.data);
        end
        if (br) begin
            step();
            check_word({names[n], " shadow wb en"}, word_t'(!exp_rd[n].taken), word_t'(wb.en));
            if (!exp_rd[n].taken) check_word({names[n], " shadow data"}, 32'd3, wb.data);
        end
    endtask

    initial begin
        word_t rdat;
        rng = 32'hb3a5f872;
        errors = 0;
        checks = 0;
        i_arst_n = 1'b0;
        issue = '0;
        ext_req = '0;
        build_table();
        limit = (ids.size() + pre_idx.size() + st_idx.size() + 10) * 20;
        fork
            begin
                repeat (limit) @(posedge i_clk);
                $display("watchdog ran out after %0d cycles, the DUT stopped responding", limit);
                $display("** FAIL **");
                $finish;
            end
        join_none
        repeat (8) @(posedge i_clk);
        #1 i_arst_n = 1'b1;
        step();
        check_true("o_wb.en high after reset", !wb.en);
        check_true("o_redirect.taken high after reset", !redirect.taken);
        check_true("external ack high after reset", !ext_rsp.ack);
        check_true("o_ready low after reset", ready);
        for (int j = 0; j < pre_idx.size(); j++) begin
            ext_xfer(1'b1, pre_idx[j], model[pre_idx[j]], rdat);
        end
        for (int n = 0; n < ids.size(); n++) begin
            if (contend[n]) begin
                fork
                    run_entry(n);
                    ext_check($sformatf("contention ext read %0d", n), pre_idx[n % 8], n % 3);
                join
            end else begin
                run_entry(n);
            end
        end
        foreach (st_idx[j]) begin
            ext_check($sformatf("ext readback word %0d", st_idx[j]), st_idx[j], 0);
        end
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.u_backend_sva.fail_count);
        if (errors == 0 && i_dut.u_backend_sva.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* testbench/backend_sva.sv */
`timescale 1ns/1ns

module backend_sva (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  wb_pkg::wb_req_t i_m0_req,
    input  wb_pkg::wb_rsp_t i_m0_rsp,
    input  wb_pkg::wb_req_t i_m1_req,
    input  wb_pkg::wb_rsp_t i_m1_rsp,
    input  wb_pkg::wb_rsp_t i_s_rsp,
    input  logic            i_hold,
    input  logic            i_flush,
    input  isa_pkg::id_ex_t i_ex
);

    int fail_count = 0;     // failed assertions so far

    // ****************************************
    // arbiter master ports
    // ****************************************

    ack_in_cycle_m0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_m0_rsp.ack |-> (i_m0_req.cyc && i_m0_req.stb))
        else begin
            $error("ack to the load/store unit outside of its cycle");
            fail_count++;
        end

    ack_in_cycle_m1: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_m1_rsp.ack |-> (i_m1_req.cyc && i_m1_req.stb))
        else begin
            $error("ack to the external port outside of its cycle");
            fail_count++;
        end

    req_stable_m0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_m0_req.cyc && i_m0_req.stb && !i_m0_rsp.ack) |=>
        (i_m0_req.cyc && $stable({i_m0_req.we, i_m0_req.adr, i_m0_req.dat, i_m0_req.sel})))
        else begin
            $error("load/store unit request changed before ack");
            fail_count++;
        end

    req_stable_m1: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_m1_req.cyc && i_m1_req.stb && !i_m1_rsp.ack) |=>
        (i_m1_req.cyc && $stable({i_m1_req.we, i_m1_req.adr, i_m1_req.dat, i_m1_req.sel})))
        else begin
            $error("external request changed before ack");
            fail_count++;
        end

    // each memory ack goes to exactly one master and no master is acked without one
    one_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((i_m0_rsp.ack | i_m1_rsp.ack) == i_s_rsp.ack) && !(i_m0_rsp.ack && i_m1_rsp.ack))
        else begin
            $error("memory ack not passed to exactly one master");
            fail_count++;
        end

    // the ID/EX register must keep its contents during a memory wait
    hold_keeps_ex: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_hold && !i_flush) |=> $stable(i_ex))
        else begin
            $error("ID/EX register changed while held");
            fail_count++;
        end

endmodule

bind backend_top backend_sva u_backend_sva (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_m0_req (lsu_req),
    .i_m0_rsp (lsu_rsp),
    .i_m1_req (i_ext_req),
    .i_m1_rsp (o_ext_rsp),
    .i_s_rsp  (mem_rsp),
    .i_hold   (hold),
    .i_flush  (o_redirect.taken),
    .i_ex     (ex_q)
);

/* hw/backend_top.sv */
`timescale 1ns/1ns

module backend_top (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  isa_pkg::id_ex_t     i_issue,
    output logic                o_ready,
    output isa_pkg::wb_result_t o_wb,
    output isa_pkg::redirect_t  o_redirect,
    input  wb_pkg::wb_req_t     i_ext_req,
    output wb_pkg::wb_rsp_t     o_ext_rsp
);
    import isa_pkg::*;
    import wb_pkg::*;

    id_ex_t     ex_q;
    word_t      ex_addr;
    wb_result_t alu_wb;
    wb_result_t load_wb;
    logic       hold;
    wb_req_t    lsu_req;
    wb_rsp_t    lsu_rsp;
    wb_req_t    mem_req;
    wb_rsp_t    mem_rsp;

    reg_id_ex u_reg_id_ex (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_hold   (hold),
        .i_flush  (o_redirect.taken),
        .i_id     (i_issue),
        .o_ex     (ex_q)
    );

    exec_unit u_exec_unit (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_ex       (ex_q),
        .i_hold     (hold),
        .o_addr     (ex_addr),
        .o_wb       (alu_wb),
        .o_redirect (o_redirect)
    );

    load_store_unit u_load_store_unit (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_ex     (ex_q),
        .i_addr   (ex_addr),
        .o_hold   (hold),
        .o_wb_req (lsu_req),
        .i_wb_rsp (lsu_rsp),
        .o_load   (load_wb)
    );

    wb_arbiter u_wb_arbiter (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_m0_req (lsu_req),
        .o_m0_rsp (lsu_rsp),
        .i_m1_req (i_ext_req),
        .o_m1_rsp (o_ext_rsp),
        .o_s_req  (mem_req),
        .i_s_rsp  (mem_rsp)
    );

    data_ram u_data_ram (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (mem_req),
        .o_rsp    (mem_rsp)
    );

    // the ALU path is stalled while a load is finishing, so both never collide
    assign o_wb    = load_wb.en ? load_wb : alu_wb;
    assign o_ready = ~hold;

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module data_ram (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  wb_pkg::wb_req_t i_req,
    output wb_pkg::wb_rsp_t o_rsp
);

    localparam int idx_w = $clog2(`CORE_MEM_WORDS);

    logic [`CORE_XLEN-1:0] mem [`CORE_MEM_WORDS];
    logic [`CORE_XLEN-1:0] rdat_q;
    logic [idx_w-1:0]      idx;
    logic                  access;
    logic                  ack_q;

    // one access per request, the ack cycle itself starts nothing
    assign access = i_req.cyc & i_req.stb & ~ack_q;
    assign idx    = i_req.adr[idx_w-1:0];      // upper address bits wrap

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rdat_q <= mem[idx];
            if (i_req.we) begin
                for (int b = 0; b < `CORE_XLEN/8; b++) begin
                    if (i_req.sel[b]) begin
                        mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign o_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

/* hw/wb_arbiter.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module wb_arbiter (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  wb_pkg::wb_req_t i_m0_req,
    output wb_pkg::wb_rsp_t o_m0_rsp,
    input  wb_pkg::wb_req_t i_m1_req,
    output wb_pkg::wb_rsp_t o_m1_rsp,
    output wb_pkg::wb_req_t o_s_req,
    input  wb_pkg::wb_rsp_t i_s_rsp
);

    logic last_q;       // master that won the last grant
    logic busy_q;       // the bus was granted in the previous cycle
    logic gnt_any;
    logic gnt_m1;
    logic last_cyc;
    logic other_cyc;

    assign gnt_any   = i_m0_req.cyc | i_m1_req.cyc;
    assign last_cyc  = last_q ? i_m1_req.cyc : i_m0_req.cyc;
    assign other_cyc = last_q ? i_m0_req.cyc : i_m1_req.cyc;

    always_comb begin
        if (busy_q && last_cyc) begin
            gnt_m1 = last_q;            // the owner keeps the bus for its whole cycle
        end else if (other_cyc) begin
            gnt_m1 = ~last_q;
        end else begin
            gnt_m1 = last_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_q <= 1'b1;             // pipeline side is served first
            busy_q <= 1'b0;
        end else begin
            busy_q <= gnt_any;
            if (gnt_any) begin
                last_q <= gnt_m1;
            end
        end
    end

    // ****************************************
    // routing
    // ****************************************

    assign o_s_req  = !gnt_any ? '0 : (gnt_m1 ? i_m1_req : i_m0_req);
    assign o_m0_rsp = '{ack: i_s_rsp.ack & gnt_any & ~gnt_m1, dat: i_s_rsp.dat};
    assign o_m1_rsp = '{ack: i_s_rsp.ack & gnt_any & gnt_m1, dat: i_s_rsp.dat};

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module load_store_unit (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  isa_pkg::id_ex_t       i_ex,
    input  logic [`CORE_XLEN-1:0] i_addr,
    output logic                  o_hold,
    output wb_pkg::wb_req_t       o_wb_req,
    input  wb_pkg::wb_rsp_t       i_wb_rsp,
    output isa_pkg::wb_result_t   o_load
);
    import isa_pkg::*;
    import wb_pkg::*;

    localparam int sel_w = `CORE_XLEN / 8;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_done
    } lsu_state_e;

    lsu_state_e             state_q;
    logic                   busy;
    logic                   start;
    logic [1:0]             lane;
    logic [sel_w-1:0]       st_sel;
    word_t                  st_dat;
    word_t                  ld_shift;
    word_t                  ld_val;
    logic                   we_q;
    logic [`CORE_XLEN-3:0]  adr_q;
    word_t                  dat_q;
    logic [sel_w-1:0]       sel_q;
    logic [1:0]             lane_q;
    mem_size_e              size_q;
    logic                   unsigned_q;
    logic [`CORE_REG_W-1:0] rd_q;
    word_t                  load_q;

    assign busy  = (state_q == st_access);
    assign start = i_ex.valid && !busy &&
                   (i_ex.agu_op == agu_load || i_ex.agu_op == agu_store);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= st_idle;
        end else if (busy) begin
            if (i_wb_rsp.ack) begin
                state_q <= st_done;     // load data shows on o_load next
            end
        end else begin
            state_q <= start ? st_access : st_idle;
        end
    end

    // ****************************************
    // lane steering
    // ****************************************

    always_comb begin
        lane   = i_addr[1:0];
        st_sel = '1;
        st_dat = i_ex.src_b;
        case (i_ex.mem_size)
            mem_byte: begin
                st_sel = sel_w'(1) << i_addr[1:0];
                st_dat = {4{i_ex.src_b[7:0]}};
            end
            mem_half: begin
                lane   = {i_addr[1], 1'b0};     // aligned down to the half
                st_sel = i_addr[1] ? 4'b1100 : 4'b0011;
                st_dat = {2{i_ex.src_b[15:0]}};
            end
            default: lane = 2'b00;
        endcase
    end

    assign ld_shift = i_wb_rsp.dat >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            mem_byte: ld_val = {{24{~unsigned_q & ld_shift[7]}}, ld_shift[7:0]};
            mem_half: ld_val = {{16{~unsigned_q & ld_shift[15]}}, ld_shift[15:0]};
            default:  ld_val = i_wb_rsp.dat;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            we_q       <= (i_ex.agu_op == agu_store);
            adr_q      <= i_addr[`CORE_XLEN-1:2];
            dat_q      <= st_dat;
            sel_q      <= st_sel;
            lane_q     <= lane;
            size_q     <= i_ex.mem_size;
            unsigned_q <= i_ex.mem_unsigned;
            rd_q       <= i_ex.rd;
        end
        if (busy && i_wb_rsp.ack) begin
            load_q <= ld_val;
        end
    end

    // cyc and stb drop the cycle after ack as the state leaves access
    assign o_wb_req = '{cyc: busy, stb: busy, we: we_q, adr: adr_q, dat: dat_q, sel: sel_q};
    assign o_hold   = busy;
    assign o_load   = '{en: (state_q == st_done) && !we_q, rd: rd_q, data: load_q};

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module exec_unit (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  isa_pkg::id_ex_t       i_ex,
    input  logic                  i_hold,
    output logic [`CORE_XLEN-1:0] o_addr,
    output isa_pkg::wb_result_t   o_wb,
    output isa_pkg::redirect_t    o_redirect
);
    import isa_pkg::*;

    localparam int shamt_w = $clog2(`CORE_XLEN);
    localparam int half_w  = `CORE_XLEN / 2;

    word_t                  ofs_sext;
    word_t                  pc_plus4;
    word_t                  alu_res;
    word_t                  wb_data;
    word_t                  target;
    logic [shamt_w-1:0]     shamt;
    logic                   is_mem;
    logic                   taken;
    logic                   wb_en_q;
    logic [`CORE_REG_W-1:0] wb_rd_q;
    word_t                  wb_data_q;

    assign ofs_sext = {{(`CORE_XLEN-`CORE_OFS_W){i_ex.offset[`CORE_OFS_W-1]}}, i_ex.offset};
    assign pc_plus4 = i_ex.pc + word_t'(4);
    assign shamt    = i_ex.src_b[shamt_w-1:0];
    assign o_addr   = i_ex.base + ofs_sext;

    // ****************************************
    // ALU
    // ****************************************

    always_comb begin
        case (i_ex.alu_op)
            alu_add:    alu_res = i_ex.src_a + i_ex.src_b;
            alu_sub:    alu_res = i_ex.src_a - i_ex.src_b;
            alu_and:    alu_res = i_ex.src_a & i_ex.src_b;
            alu_or:     alu_res = i_ex.src_a | i_ex.src_b;
            alu_xor:    alu_res = i_ex.src_a ^ i_ex.src_b;
            alu_slt:    alu_res = word_t'($signed(i_ex.src_a) < $signed(i_ex.src_b));
            alu_sltu:   alu_res = word_t'(i_ex.src_a < i_ex.src_b);
            alu_sll:    alu_res = i_ex.src_a << shamt;
            alu_srl:    alu_res = i_ex.src_a >> shamt;
            alu_sra:    alu_res = word_t'($signed(i_ex.src_a) >>> shamt);
            alu_lui:    alu_res = {i_ex.src_b[half_w-1:0], {half_w{1'b0}}};
            alu_pass_b: alu_res = i_ex.src_b;
            default:    alu_res = '0;
        endcase
    end

    // ****************************************
    // branch resolution
    // ****************************************

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4 + (ofs_sext << 2);   // word offset from the delay slot
        case (i_ex.agu_op)
            agu_beq: taken = (i_ex.src_a == i_ex.src_b);
            agu_bne: taken = (i_ex.src_a != i_ex.src_b);
            agu_jump, agu_jal: begin
                taken  = 1'b1;
                target = {pc_plus4[`CORE_XLEN-1 -: (`CORE_XLEN-`CORE_OFS_W-2)],
                          i_ex.offset, 2'b00};
            end
            default: taken = 1'b0;
        endcase
    end

    // a branch behind a memory access waits until the access is over
    assign o_redirect = '{taken: i_ex.valid & taken & ~i_hold, target: target};

    assign is_mem  = (i_ex.agu_op == agu_load) || (i_ex.agu_op == agu_store);
    assign wb_data = (i_ex.agu_op == agu_jal) ? i_ex.pc + word_t'(8) : alu_res;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= i_ex.valid & i_ex.reg_wr_en & ~is_mem & ~i_hold;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_rd_q   <= i_ex.rd;
        wb_data_q <= wb_data;
    end

    assign o_wb = '{en: wb_en_q, rd: wb_rd_q, data: wb_data_q};

endmodule

/* hw/reg_id_ex.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module reg_id_ex (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_hold,
    input  logic            i_flush,
    input  isa_pkg::id_ex_t i_id,
    output isa_pkg::id_ex_t o_ex
);

    logic            valid_q;
    isa_pkg::id_ex_t payload_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;            // bubble wins over hold
        end else if (!i_hold) begin
            valid_q <= i_id.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            payload_q <= i_id;
        end
    end

    // the valid bit of the payload copy is replaced by the reset one
    always_comb begin
        o_ex       = payload_q;
        o_ex.valid = valid_q;
    end

endmodule

/* hw/isa_pkg.sv */
`include "core_consts.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_lui    = 4'd10,
        alu_pass_b = 4'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        agu_none  = 3'd0,
        agu_load  = 3'd1,
        agu_store = 3'd2,
        agu_beq   = 3'd3,
        agu_bne   = 3'd4,
        agu_jump  = 3'd5,
        agu_jal   = 3'd6
    } agu_op_e;

    typedef struct packed {
        logic                   valid;
        word_t                  pc;
        logic [`CORE_REG_W-1:0] rd;
        alu_op_e                alu_op;
        agu_op_e                agu_op;
        word_t                  src_a;          // shifts take the value to shift here
        word_t                  src_b;          // also carries the store data
        word_t                  base;
        logic [`CORE_OFS_W-1:0] offset;
        wb_pkg::mem_size_e      mem_size;
        logic                   mem_unsigned;
        logic                   reg_wr_en;
    } id_ex_t;

    typedef struct packed {
        logic                   en;
        logic [`CORE_REG_W-1:0] rd;
        word_t                  data;
    } wb_result_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* hw/wb_pkg.sv */
`include "core_consts.svh"

package wb_pkg;

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    // classic cycle, master side
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`CORE_XLEN-3:0]   adr;   // word address
        logic [`CORE_XLEN-1:0]   dat;
        logic [`CORE_XLEN/8-1:0] sel;   // one bit per byte lane
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`CORE_XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

/* hw/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ****************************************
// datapath widths, fixed by the instruction set
// ****************************************

`define CORE_XLEN      32
`define CORE_REG_W     5

// immediate field of the jump format, branches use its sign-extended value
`define CORE_OFS_W     26

// ****************************************
// data memory
// ****************************************

// depth in 32-bit words
`define CORE_MEM_WORDS 256

`endif
